// ==== vlog.f ====
verilog/gpuGeomPkg.sv
verilog/gpuRasterPkg.sv
verilog/triBoundBox.sv
verilog/triEdgeSetup.sv
verilog/pixelPairTest.sv
verilog/triSetupUnit.sv
verif/tbTriSetup.sv

// ==== Bender.yml ====
package:
  name: tri_setup_unit

sources:
  - verilog/gpuGeomPkg.sv
  - verilog/gpuRasterPkg.sv
  - verilog/triBoundBox.sv
  - verilog/triEdgeSetup.sv
  - verilog/pixelPairTest.sv
  - verilog/triSetupUnit.sv
  - target: test
    files:
      - verif/tbTriSetup.sv

// ==== verif/tbTriSetup.sv ====
// Stimulus table of eight triangles with fixed and LCG query pairs; stops at the first mismatch
`timescale 1ns/1ps

module tbTriSetup import gpuGeomPkg::*; import gpuRasterPkg::*; ();

	localparam int nTri    = 8;
	localparam int nCol    = 12;
	localparam int nFixQ   = 3;  // Table pairs per triangle
	localparam int nRandQ  = 3;  // LCG pairs per triangle
	localparam int waitMax = 16; // Cycles before a wait gives up

	logic    i_clk, i_rst, i_start, i_pixValid;
	coordT   i_x0, i_y0, i_x1, i_y1, i_x2, i_y2, i_pixX, i_pixY;
	drawPosT i_daX0, i_daY0, i_daX1, i_daY1;
	logic    o_busy, o_done, o_reject, o_nullDet;
	coordT   o_minX, o_maxX, o_minY, o_maxY;
	logic    o_resValid, o_inBoxL, o_inBoxR, o_coverL, o_coverR;

	// x0, y0, x1, y1, x2, y2, daX0, daY0, daX1, daY1, reject, nullDet
	int triTab [nTri][nCol] = '{
		'{  10,  10,   30,  10,  10,   30, 0, 0,  100,  100, 0, 0}, // Inside, det < 0
		'{  10,  10,   10,  30,  30,   10, 0, 0,  100,  100, 0, 0}, // Mirror winding
		'{ -20,   5,   50, -10,  40,   60, 0, 0,   30,   40, 0, 0}, // Clipped on all sides
		'{ 200,  10,  220,  10, 210,   30, 0, 0,  100,  100, 1, 0}, // Right of draw area
		'{   0,   0,   10,  10,  20,   20, 0, 0,  100,  100, 0, 1}, // Collinear
		'{1000,   0, 2023, 511, -24, -512, 0, 0, 1023, 1023, 0, 0}, // Spans right at the limits
		'{   0,   0, 1024,  10,  10,   20, 0, 0, 1023, 1023, 1, 0}, // X span 1024
		'{ 100, 100,  110, 612,  90,  100, 0, 0, 1023, 1023, 1, 0}  // Y span 512
	};

	// Query pairs as pixX, pixY; edge and vertex points where the bias decides
	int qTab [nTri][nFixQ][2] = '{
		'{'{20, 10}, '{10, 20}, '{20, 20}},
		'{'{20, 10}, '{10, 20}, '{20, 20}},
		'{'{0, 0}, '{30, 40}, '{10, 20}},
		'{'{100, 20}, '{210, 20}, '{0, 0}},
		'{'{10, 10}, '{4, 4}, '{50, 50}},
		'{'{1000, 0}, '{500, 100}, '{1022, 511}},
		'{'{0, 0}, '{512, 10}, '{10, 19}},
		'{'{100, 100}, '{90, 100}, '{104, 300}}
	};

	int unsigned randState = 90;
	int r [nCol];                    // Current triangle row
	int eMinX, eMaxX, eMinY, eMaxY;  // Model box

	triSetupUnit DUT (.*);

	always #5 i_clk = ~i_clk; // 10 ns period

	// -------------------------------------------------------------------
	// Reference model
	// -------------------------------------------------------------------
	function automatic int nextRand();
		randState = randState * 32'd1103515245 + 32'd12345;
		return (randState >> 16) & 32'h7fff;
	endfunction

	function automatic int min3(int a, int b, int c);
		int m;
		m = (a < b) ? a : b;
		return (m < c) ? m : c;
	endfunction

	function automatic int max3(int a, int b, int c);
		int m;
		m = (a > b) ? a : b;
		return (m > c) ? m : c;
	endfunction

	// Edge value with top-left bias folded in
	function automatic int edgeVal(int cx, int cy, int vx, int vy, int px, int py);
		int bias;
		bias = (cx < 0 || (cx == 0 && cy < 0)) ? -1 : 0;
		return cx * (px - vx) + cy * (py - vy) + bias;
	endfunction

	function automatic int inBoxModel(int px, int py);
		return (px >= eMinX && px <= eMaxX && py >= eMinY && py <= eMaxY) ? 1 : 0;
	endfunction

	function automatic int coverModel(int px, int py);
		int w0, w1, w2;
		w0 = edgeVal(r[3] - r[5], r[4] - r[2], r[2], r[3], px, py); // V1 to V2
		w1 = edgeVal(r[5] - r[1], r[0] - r[4], r[4], r[5], px, py); // V2 to V0
		w2 = edgeVal(r[1] - r[3], r[2] - r[0], r[0], r[1], px, py); // V0 to V1
		if (!inBoxModel(px, py))
			return 0;
		return ((w0 >= 0 && w1 >= 0 && w2 >= 0) || (w0 < 0 && w1 < 0 && w2 < 0)) ? 1 : 0;
	endfunction

	// -------------------------------------------------------------------
	// Checks and waits
	// -------------------------------------------------------------------
	task automatic failRun(string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkVal(string name, int got, int exp);
		if (got != exp) begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
			failRun("Value mismatch");
		end
	endtask

	task automatic waitDone();
		int cycles;
		cycles = 0;
		do begin
			@(negedge i_clk);
			cycles++;
			i_start = 1'b0; // One-cycle pulse
			if (!o_done)
				checkVal("o_busy", o_busy, 1); // Busy before done
		end while (!o_done && cycles < waitMax);
		if (!o_done)
			failRun("Timeout, o_done never arrived after the start pulse");
		checkVal("done latency", cycles, 2);
		checkVal("o_busy", o_busy, 1);
	endtask

	task automatic waitResult();
		int cycles;
		cycles = 0;
		do begin
			@(negedge i_clk);
			cycles++;
		end while (!o_resValid && cycles < waitMax);
		if (!o_resValid)
			failRun("Timeout, o_resValid never arrived after a pixel query");
		checkVal("result latency", cycles, 1);
	endtask

	// -------------------------------------------------------------------
	// One triangle: setup, then back-to-back queries
	// -------------------------------------------------------------------
	task automatic runTriangle(int t);
		int px, py, pxL;
		r = triTab[t];
		eMinX = (min3(r[0], r[2], r[4]) > r[6]) ? min3(r[0], r[2], r[4]) : r[6];
		eMaxX = (max3(r[0], r[2], r[4]) < r[8]) ? max3(r[0], r[2], r[4]) : r[8];
		eMinY = (min3(r[1], r[3], r[5]) > r[7]) ? min3(r[1], r[3], r[5]) : r[7];
		eMaxY = (max3(r[1], r[3], r[5]) < r[9]) ? max3(r[1], r[3], r[5]) : r[9];
		@(negedge i_clk);
		{i_x0, i_y0, i_x1, i_y1, i_x2, i_y2} = {coordT'(r[0]), coordT'(r[1]), coordT'(r[2]),
			coordT'(r[3]), coordT'(r[4]), coordT'(r[5])};
		{i_daX0, i_daY0, i_daX1, i_daY1} = {drawPosT'(r[6]), drawPosT'(r[7]),
			drawPosT'(r[8]), drawPosT'(r[9])};
		i_start = 1'b1;
		waitDone();
		checkVal("o_minX", o_minX, eMinX);
		checkVal("o_maxX", o_maxX, eMaxX);
		checkVal("o_minY", o_minY, eMinY);
		checkVal("o_maxY", o_maxY, eMaxY);
		checkVal("o_reject", o_reject, r[10]);
		checkVal("o_nullDet", o_nullDet, r[11]);
		@(negedge i_clk);
		checkVal("o_busy", o_busy, 0); // Idle again, queries allowed
		checkVal("o_done", o_done, 0);
		for (int q = 0; q < nFixQ + nRandQ; q++) begin
			if (q < nFixQ) begin
				px = qTab[t][q][0];
				py = qTab[t][q][1];
			end else begin
				px = eMinX - 4 + nextRand() % 48; // Around the top-left box corner
				py = eMinY - 4 + nextRand() % 48;
			end
			i_pixValid = 1'b1; // Driven in the cycle the previous result shows
			i_pixX = coordT'(px);
			i_pixY = coordT'(py);
			waitResult();
			pxL = px & -2; // Even pixel of the pair
			checkVal("o_inBoxL", o_inBoxL, inBoxModel(pxL, py));
			checkVal("o_inBoxR", o_inBoxR, inBoxModel(pxL + 1, py));
			checkVal("o_coverL", o_coverL, coverModel(pxL, py));
			checkVal("o_coverR", o_coverR, coverModel(pxL + 1, py));
		end
		i_pixValid = 1'b0;
	endtask

	// -------------------------------------------------------------------
	// Main sequence
	// -------------------------------------------------------------------
	initial begin
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_start = 1'b0;
		i_pixValid = 1'b0;
		{i_x0, i_y0, i_x1, i_y1, i_x2, i_y2, i_pixX, i_pixY} = '0;
		{i_daX0, i_daY0, i_daX1, i_daY1} = '0;
		repeat (8) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		@(negedge i_clk);
		checkVal("o_busy", o_busy, 0); // Quiet after reset
		checkVal("o_done", o_done, 0);
		checkVal("o_resValid", o_resValid, 0);
		for (int t = 0; t < nTri; t++)
			runTriangle(t);
		@(negedge i_clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog/triSetupUnit.sv ====
// Start is taken only when idle, results are valid from the done cycle, queries must wait while busy
`timescale 1ns/1ps

module triSetupUnit import gpuGeomPkg::*; import gpuRasterPkg::*; (
	input  logic    i_clk,
	input  logic    i_rst,
	input  logic    i_start,
	input  coordT   i_x0,
	input  coordT   i_y0,
	input  coordT   i_x1,
	input  coordT   i_y1,
	input  coordT   i_x2,
	input  coordT   i_y2,
	input  drawPosT i_daX0,
	input  drawPosT i_daY0,
	input  drawPosT i_daX1,
	input  drawPosT i_daY1,
	input  logic    i_pixValid,
	input  coordT   i_pixX,
	input  coordT   i_pixY,
	output logic    o_busy,
	output logic    o_done,
	output logic    o_reject,
	output logic    o_nullDet,
	output coordT   o_minX,
	output coordT   o_maxX,
	output coordT   o_minY,
	output coordT   o_maxY,
	output logic    o_resValid,
	output logic    o_inBoxL,
	output logic    o_inBoxR,
	output logic    o_coverL,
	output logic    o_coverR
);

	setupStateT setupState;
	logic       startAcc;

	// Command registers
	coordT   cmdX0, cmdY0, cmdX1, cmdY1, cmdX2, cmdY2;
	drawPosT cmdDaX0, cmdDaY0, cmdDaX1, cmdDaY1;

	// Combinational setup results
	coordT bbMinX, bbMaxX, bbMinY, bbMaxY;
	logic  bbReject;
	coordT cX0, cY0, cX1, cY1, cX2, cY2;
	logic  cBias0, cBias1, cBias2, cNullDet;

	// Setup registers feeding the query stage
	coordT sCoefX0, sCoefY0, sCoefX1, sCoefY1, sCoefX2, sCoefY2;
	logic  sBias0, sBias1, sBias2;

	// -------------------------------------------------------------------
	// Sequencer
	// -------------------------------------------------------------------
	assign startAcc = i_start && (setupState == stIdle); // Ignored while busy

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			setupState <= stIdle;
		end else begin
			case (setupState)
				stIdle:    if (startAcc) setupState <= stLatch;
				stLatch:   setupState <= stCompute;
				stCompute: setupState <= stIdle;
				default:   setupState <= stIdle;
			endcase
		end
	end

	assign o_busy = (setupState != stIdle);
	assign o_done = (setupState == stCompute); // Cycle 2 after start

	// -------------------------------------------------------------------
	// Command and setup registers
	// -------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (startAcc) begin
			cmdX0   <= i_x0;
			cmdY0   <= i_y0;
			cmdX1   <= i_x1;
			cmdY1   <= i_y1;
			cmdX2   <= i_x2;
			cmdY2   <= i_y2;
			cmdDaX0 <= i_daX0;
			cmdDaY0 <= i_daY0;
			cmdDaX1 <= i_daX1;
			cmdDaY1 <= i_daY1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (setupState == stLatch) begin // Setup logic has settled on the command
			o_minX    <= bbMinX;
			o_maxX    <= bbMaxX;
			o_minY    <= bbMinY;
			o_maxY    <= bbMaxY;
			o_reject  <= bbReject;
			o_nullDet <= cNullDet;
			sCoefX0   <= cX0;
			sCoefY0   <= cY0;
			sCoefX1   <= cX1;
			sCoefY1   <= cY1;
			sCoefX2   <= cX2;
			sCoefY2   <= cY2;
			sBias0    <= cBias0;
			sBias1    <= cBias1;
			sBias2    <= cBias2;
		end
	end

	// -------------------------------------------------------------------
	// Setup and query stages
	// -------------------------------------------------------------------
	triBoundBox uBox (
		.i_x0(cmdX0), .i_y0(cmdY0), .i_x1(cmdX1), .i_y1(cmdY1), .i_x2(cmdX2), .i_y2(cmdY2),
		.i_daX0(cmdDaX0), .i_daY0(cmdDaY0), .i_daX1(cmdDaX1), .i_daY1(cmdDaY1),
		.o_minX(bbMinX), .o_maxX(bbMaxX), .o_minY(bbMinY), .o_maxY(bbMaxY),
		.o_reject(bbReject)
	);

	triEdgeSetup uEdge (
		.i_x0(cmdX0), .i_y0(cmdY0), .i_x1(cmdX1), .i_y1(cmdY1), .i_x2(cmdX2), .i_y2(cmdY2),
		.o_coefX0(cX0), .o_coefY0(cY0), .o_coefX1(cX1), .o_coefY1(cY1),
		.o_coefX2(cX2), .o_coefY2(cY2),
		.o_bias0(cBias0), .o_bias1(cBias1), .o_bias2(cBias2), .o_nullDet(cNullDet)
	);

	pixelPairTest uPair (
		.i_clk(i_clk), .i_rst(i_rst), .i_pixValid(i_pixValid), .i_pixX(i_pixX), .i_pixY(i_pixY),
		.i_x0(cmdX0), .i_y0(cmdY0), .i_x1(cmdX1), .i_y1(cmdY1), .i_x2(cmdX2), .i_y2(cmdY2),
		.i_coefX0(sCoefX0), .i_coefY0(sCoefY0), .i_coefX1(sCoefX1), .i_coefY1(sCoefY1),
		.i_coefX2(sCoefX2), .i_coefY2(sCoefY2),
		.i_bias0(sBias0), .i_bias1(sBias1), .i_bias2(sBias2),
		.i_minX(o_minX), .i_maxX(o_maxX), .i_minY(o_minY), .i_maxY(o_maxY),
		.o_resValid(o_resValid), .o_inBoxL(o_inBoxL), .o_inBoxR(o_inBoxR),
		.o_coverL(o_coverL), .o_coverR(o_coverR)
	);

	// Queries see half-updated setup while busy
	assert property (@(posedge i_clk) disable iff (i_rst) !(i_pixValid && o_busy))
		else $error("Pixel query issued during setup");

	assert property (@(posedge i_clk) disable iff (i_rst) o_done |=> !o_done)
		else $error("Done held longer than one cycle");

endmodule

// ==== verilog/pixelPairTest.sv ====
// One query per cycle with result one cycle later and no back-pressure; setup inputs must be stable
`timescale 1ns/1ps

module pixelPairTest import gpuGeomPkg::*; import gpuRasterPkg::*; (
	input  logic  i_clk,
	input  logic  i_rst,
	input  logic  i_pixValid,
	input  coordT i_pixX,
	input  coordT i_pixY,
	input  coordT i_x0,
	input  coordT i_y0,
	input  coordT i_x1,
	input  coordT i_y1,
	input  coordT i_x2,
	input  coordT i_y2,
	input  coordT i_coefX0,
	input  coordT i_coefY0,
	input  coordT i_coefX1,
	input  coordT i_coefY1,
	input  coordT i_coefX2,
	input  coordT i_coefY2,
	input  logic  i_bias0,
	input  logic  i_bias1,
	input  logic  i_bias2,
	input  coordT i_minX,
	input  coordT i_maxX,
	input  coordT i_minY,
	input  coordT i_maxY,
	output logic  o_resValid,
	output logic  o_inBoxL,
	output logic  o_inBoxR,
	output logic  o_coverL,
	output logic  o_coverR
);

	// w = coefX*(px-vx) + coefY*(py-vy) + bias
	function automatic edgeValT edgeEval(coordT coefX, coordT coefY, coordT vx, coordT vy,
			coordT px, coordT py, logic bias);
		logic signed [coordWidth:0] dx; // Extra bit keeps distance exact
		logic signed [coordWidth:0] dy;
		edgeValT biasVal;
		dx = px - vx;
		dy = py - vy;
		biasVal = {edgeWidth{bias}}; // All ones is -1
		edgeEval = coefX * dx + coefY * dy + biasVal;
	endfunction

	// Either winding, all non-negative or all negative
	function automatic logic insideTri(edgeValT w0, edgeValT w1, edgeValT w2);
		logic n0, n1, n2;
		n0 = w0[edgeWidth-1];
		n1 = w1[edgeWidth-1];
		n2 = w2[edgeWidth-1];
		insideTri = (!n0 && !n1 && !n2) || (n0 && n1 && n2);
	endfunction

	coordT   pxL, pxR;
	edgeValT w0L, w1L, w2L, w0R, w1R, w2R;
	logic    rowIn, inBoxL, inBoxR;

	// -------------------------------------------------------------------
	// Edge evaluation
	// -------------------------------------------------------------------
	assign pxL = {i_pixX[coordWidth-1:1], 1'b0}; // Even pixel
	assign pxR = {i_pixX[coordWidth-1:1], 1'b1}; // Odd neighbour

	assign w0L = edgeEval(i_coefX0, i_coefY0, i_x1, i_y1, pxL, i_pixY, i_bias0);
	assign w1L = edgeEval(i_coefX1, i_coefY1, i_x2, i_y2, pxL, i_pixY, i_bias1);
	assign w2L = edgeEval(i_coefX2, i_coefY2, i_x0, i_y0, pxL, i_pixY, i_bias2);

	// One step right adds the X coefficient
	assign w0R = w0L + i_coefX0;
	assign w1R = w1L + i_coefX1;
	assign w2R = w2L + i_coefX2;

	// Clipped box, all sides inclusive
	assign rowIn  = (i_pixY >= i_minY) && (i_pixY <= i_maxY);
	assign inBoxL = rowIn && (pxL >= i_minX) && (pxL <= i_maxX);
	assign inBoxR = rowIn && (pxR >= i_minX) && (pxR <= i_maxX);

	// -------------------------------------------------------------------
	// Result register
	// -------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_resValid <= 1'b0;
		end else begin
			o_resValid <= i_pixValid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_pixValid) begin // Hold last result between queries
			o_inBoxL <= inBoxL;
			o_inBoxR <= inBoxR;
			o_coverL <= inBoxL && insideTri(w0L, w1L, w2L);
			o_coverR <= inBoxR && insideTri(w0R, w1R, w2R);
		end
	end

	// No stale result straight out of reset
	assert property (@(posedge i_clk) $past(i_rst) |-> !o_resValid)
		else $error("Result valid in the cycle after reset");

endmodule

// ==== verilog/triEdgeSetup.sv ====
// Combinational; coefficients are 12-bit and only exact for triangles inside the span limits
`timescale 1ns/1ps

module triEdgeSetup import gpuGeomPkg::*; import gpuRasterPkg::*; (
	input  coordT i_x0,
	input  coordT i_y0,
	input  coordT i_x1,
	input  coordT i_y1,
	input  coordT i_x2,
	input  coordT i_y2,
	output coordT o_coefX0,
	output coordT o_coefY0,
	output coordT o_coefX1,
	output coordT o_coefY1,
	output coordT o_coefX2,
	output coordT o_coefY2,
	output logic  o_bias0,
	output logic  o_bias1,
	output logic  o_bias2,
	output logic  o_nullDet
);

	// Top-left edge gets a -1 bias so shared edges fill once
	function automatic logic isTopLeft(coordT coefX, coordT coefY);
		isTopLeft = coefX[coordWidth-1] || ((coefX == '0) && coefY[coordWidth-1]);
	endfunction

	coordT dX10, dY10, dX20, dY20; // Vertex-0 relative spans
	detT   det;

	// -------------------------------------------------------------------
	// Edge coefficients
	// -------------------------------------------------------------------
	// Edge 0, V1 to V2
	assign o_coefX0 = i_y1 - i_y2;
	assign o_coefY0 = i_x2 - i_x1;
	// Edge 1, V2 to V0
	assign o_coefX1 = i_y2 - i_y0;
	assign o_coefY1 = i_x0 - i_x2;
	// Edge 2, V0 to V1
	assign o_coefX2 = i_y0 - i_y1;
	assign o_coefY2 = i_x1 - i_x0;

	assign o_bias0 = isTopLeft(o_coefX0, o_coefY0);
	assign o_bias1 = isTopLeft(o_coefX1, o_coefY1);
	assign o_bias2 = isTopLeft(o_coefX2, o_coefY2);

	// -------------------------------------------------------------------
	// Determinant
	// -------------------------------------------------------------------
	assign dX10 = i_x1 - i_x0;
	assign dY10 = i_y1 - i_y0;
	assign dX20 = i_x2 - i_x0;
	assign dY20 = i_y2 - i_y0;

	assign det = dX20 * dY10 - dY20 * dX10; // Sign gives winding
	assign o_nullDet = (det == '0);         // Collinear or degenerate

endmodule

// ==== verilog/triBoundBox.sv ====
// Purely combinational; draw area must be ordered and the clipped box is only meaningful without reject
`timescale 1ns/1ps

module triBoundBox import gpuGeomPkg::*; (
	input  coordT   i_x0,
	input  coordT   i_y0,
	input  coordT   i_x1,
	input  coordT   i_y1,
	input  coordT   i_x2,
	input  coordT   i_y2,
	input  drawPosT i_daX0,
	input  drawPosT i_daY0,
	input  drawPosT i_daX1,
	input  drawPosT i_daY1,
	output coordT   o_minX,
	output coordT   o_maxX,
	output coordT   o_minY,
	output coordT   o_maxY,
	output logic    o_reject
);

	function automatic coordT minOf(coordT a, coordT b);
		minOf = (a < b) ? a : b;
	endfunction

	function automatic coordT maxOf(coordT a, coordT b);
		maxOf = (a > b) ? a : b;
	endfunction

	// True outside -(lim+1)..lim
	function automatic logic outOfSpan(logic signed [coordWidth:0] d, int lim);
		outOfSpan = (d > lim) || (d < -lim - 1);
	endfunction

	coordT triMinX, triMaxX, triMinY, triMaxY; // Unclipped triangle box
	coordT daX0, daY0, daX1, daY1;             // Draw area as signed coordinates
	logic signed [coordWidth:0] dX1, dX2, dY1, dY2; // One extra bit, no wrap
	logic rejBox, rejSpan;

	// -------------------------------------------------------------------
	// Triangle box
	// -------------------------------------------------------------------
	assign triMinX = minOf(minOf(i_x0, i_x1), i_x2);
	assign triMaxX = maxOf(maxOf(i_x0, i_x1), i_x2);
	assign triMinY = minOf(minOf(i_y0, i_y1), i_y2);
	assign triMaxY = maxOf(maxOf(i_y0, i_y1), i_y2);

	// Draw bounds are unsigned, zero-extend
	assign daX0 = {{(coordWidth-drawWidth){1'b0}}, i_daX0};
	assign daY0 = {{(coordWidth-drawWidth){1'b0}}, i_daY0};
	assign daX1 = {{(coordWidth-drawWidth){1'b0}}, i_daX1};
	assign daY1 = {{(coordWidth-drawWidth){1'b0}}, i_daY1};

	// -------------------------------------------------------------------
	// Clip to draw area, bounds inclusive
	// -------------------------------------------------------------------
	assign o_minX = (triMinX < daX0) ? daX0 : triMinX;
	assign o_maxX = (triMaxX > daX1) ? daX1 : triMaxX;
	assign o_minY = (triMinY < daY0) ? daY0 : triMinY;
	assign o_maxY = (triMaxY > daY1) ? daY1 : triMaxY;

	// -------------------------------------------------------------------
	// Early reject
	// -------------------------------------------------------------------
	assign rejBox = (triMaxX < daX0) || (triMaxY < daY0)  // Left or above
	             || (triMinX > daX1) || (triMinY > daY1); // Right or below, past last pixel

	assign dX1 = i_x1 - i_x0; // Spans from vertex 0
	assign dX2 = i_x2 - i_x0;
	assign dY1 = i_y1 - i_y0;
	assign dY2 = i_y2 - i_y0;

	assign rejSpan = outOfSpan(dX1, maxSpanX) || outOfSpan(dX2, maxSpanX)
	              || outOfSpan(dY1, maxSpanY) || outOfSpan(dY2, maxSpanY);

	assign o_reject = rejBox || rejSpan;

endmodule

// ==== verilog/gpuRasterPkg.sv ====
// Edge and determinant widths are sized for spans inside the reject limits and wrap beyond them
package gpuRasterPkg;

	// -------------------------------------------------------------------
	// Edge-equation arithmetic
	// -------------------------------------------------------------------
	localparam int edgeWidth = 23; // 12b coef x 13b distance, trimmed to the useful range
	localparam int detWidth  = 22; // Two 11b x 10b products and their difference

	typedef logic signed [edgeWidth-1:0] edgeValT; // Edge function value
	typedef logic signed [detWidth-1:0]  detT;     // Twice the signed triangle area

	// Setup sequencer
	typedef enum logic [1:0] {
		stIdle,    // Waiting for a start pulse
		stLatch,   // Command held, combinational setup settling
		stCompute  // Setup registers loaded, done pulse
	} setupStateT;

endpackage

// ==== verilog/gpuGeomPkg.sv ====
// Screen geometry types with signed 12-bit vertices and 10-bit draw bounds assumed ordered X0 <= X1, Y0 <= Y1
package gpuGeomPkg;

	// -------------------------------------------------------------------
	// Widths
	// -------------------------------------------------------------------
	localparam int coordWidth = 12; // Vertex and pixel coordinates
	localparam int drawWidth  = 10; // Draw-area registers

	// Span limits measured from vertex 0
	// Negative limit is one further out than the positive one
	localparam int maxSpanX = 1023; // Lower limit -1024
	localparam int maxSpanY = 511;  // Lower limit -512

	// -------------------------------------------------------------------
	// Types
	// -------------------------------------------------------------------
	typedef logic signed [coordWidth-1:0] coordT;  // Signed screen position
	typedef logic        [drawWidth-1:0]  drawPosT; // Unsigned draw-area bound

endpackage
